// File: mouse_encoder.sv
/*
 * Mouse encoder
 * Accumulates motion reports and serves them as a four nibble packet,
 * one nibble per clear pulse
 */

`default_nettype none

`include "pad_defines.svh"

module mouse_encoder (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                clr_rise,
	input  logic                clr_level,
	input  logic [8:0]          mouse_x,
	input  logic [8:0]          mouse_y,
	input  logic [7:0]          mouse_flags,   // [0] left, [1] right
	input  logic                mouse_strobe,
	input  pad_pkg::joy_word_t  pad_buttons,
	output logic [7:0]          mouse_byte
);

	mouse_pkg::motion_t          acc_x;
	mouse_pkg::motion_t          acc_y;
	mouse_pkg::motion_t          cap_x;
	mouse_pkg::motion_t          cap_y;
	mouse_pkg::mouse_cnt_t       mouse_cnt;
	logic [`MOUSE_TO_WIDTH-1:0]  mouse_to;
	logic                        idle_full;

	assign idle_full = &mouse_to;

	// ==============================
	// Idle timeout
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mouse_to <= '0;
		end else if (clr_level) begin
			mouse_to <= '0;
		end else if (!idle_full) begin
			mouse_to <= mouse_to + `MOUSE_TO_WIDTH'(1);   // Saturates
		end
	end

	// ==============================
	// Packet position and motion
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mouse_cnt <= 2'd3;
			acc_x     <= '0;
			acc_y     <= '0;
			cap_x     <= '0;
			cap_y     <= '0;
		end else begin
			// Long idle means the console lost sync and restarts at x high
			if (idle_full)
				mouse_cnt <= 2'd3;

			if (clr_rise) begin
				mouse_cnt <= mouse_cnt + 2'd1;
				if (&mouse_cnt) begin
					cap_x <= acc_x;      // New packet starts
					cap_y <= acc_y;
					acc_x <= '0;
					acc_y <= '0;
				end
			end

			// Strobe overrides the clear above
			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse_x[7:0];
				acc_y <= mouse_y[7:0];
			end
		end
	end

	// ==============================
	// Packet nibble
	// ==============================

	assign mouse_byte[3:0] = ~{pad_buttons[7:6], mouse_flags[0], mouse_flags[1]};

	always_comb begin
		case (mouse_cnt)
			2'd0:    mouse_byte[7:4] = cap_x[7:4];
			2'd1:    mouse_byte[7:4] = cap_x[3:0];
			2'd2:    mouse_byte[7:4] = cap_y[7:4];
			default: mouse_byte[7:4] = cap_y[3:0];
		endcase
	end

endmodule

`default_nettype wire

// File: mouse_pkg.sv
/*
 * Mouse types
 * Motion bytes and the packet position
 */

`default_nettype none

package mouse_pkg;

	// ==============================
	// Motion
	// ==============================

	// Two's complement, one axis
	typedef logic [7:0] motion_t;

	// ==============================
	// Packet
	// ==============================

	// 0 x high, 1 x low, 2 y high, 3 y low
	typedef logic [1:0] mouse_cnt_t;

endpackage

`default_nettype wire

// File: pad_defines.svh
/*
 * Joypad port constants
 * Sizes shared by the pad scanner, the mouse encoder and the packages
 */

`ifndef PAD_DEFINES_SVH
`define PAD_DEFINES_SVH

// ==============================
// Pad inputs
// ==============================

// Joystick inputs behind the turbo tap
`define PAD_COUNT 5

// Raw joystick word from the host side
`define JOY_WIDTH 32

// ==============================
// Mouse
// ==============================

// Idle counter, full after 32767 cycles with clear low
`define MOUSE_TO_WIDTH 15

`endif

// File: pad_input_top.sv
/*
 * Controller port top
 * Joypad, turbo tap and mouse answers to the console strobes
 */

`default_nettype none

module pad_input_top (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [1:0]          joy_out,
	input  pad_pkg::joy_word_t  joy_a,
	input  pad_pkg::joy_word_t  joy_b,
	input  pad_pkg::joy_word_t  joy_2,
	input  pad_pkg::joy_word_t  joy_3,
	input  pad_pkg::joy_word_t  joy_4,
	input  logic [8:0]          mouse_x,
	input  logic [8:0]          mouse_y,
	input  logic [7:0]          mouse_flags,
	input  logic                mouse_strobe,
	input  logic                joy_swap,
	input  logic                turbotap,
	input  logic                buttons6,
	input  logic                mouse_en,
	output pad_pkg::nibble_t    joy_in
);

	pad_pkg::pad_word_t  pad_word;
	pad_pkg::joy_word_t  pad0_buttons;
	pad_pkg::nib_sel_t   nib_sel;
	logic                slot_first;
	logic                latch_clear;
	logic                clr_rise;
	logic                clr_level;
	logic [7:0]          mouse_byte;

	pad_scanner u_scanner (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.joy_out      (joy_out),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.joy_swap     (joy_swap),
		.turbotap     (turbotap),
		.buttons6     (buttons6),
		.pad_word     (pad_word),
		.pad0_buttons (pad0_buttons),
		.slot_first   (slot_first),
		.nib_sel      (nib_sel),
		.latch_clear  (latch_clear),
		.clr_rise     (clr_rise),
		.clr_level    (clr_level)
	);

	mouse_encoder u_mouse (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.clr_rise     (clr_rise),
		.clr_level    (clr_level),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_flags  (mouse_flags),
		.mouse_strobe (mouse_strobe),
		.pad_buttons  (pad0_buttons),
		.mouse_byte   (mouse_byte)
	);

	pad_port_mux u_mux (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.pad_word     (pad_word),
		.mouse_byte   (mouse_byte),
		.slot_first   (slot_first),
		.mouse_en     (mouse_en),
		.nib_sel      (nib_sel),
		.latch_clear  (latch_clear),
		.joy_in       (joy_in)
	);

endmodule

`default_nettype wire

// File: pad_pkg.sv
/*
 * Joypad types
 * Raw joystick words and the console side pad word
 */

`default_nettype none

`include "pad_defines.svh"

package pad_pkg;

	// ==============================
	// Host side
	// ==============================

	// Active high
	// [3:0]  right, left, down, up
	// [7:4]  I, II, select, run
	// [11:8] III to VI
	typedef logic [`JOY_WIDTH-1:0] joy_word_t;

	// ==============================
	// Console side
	// ==============================

	typedef logic [3:0] nibble_t;

	// Active low, four nibbles as the console reads them
	typedef nibble_t [3:0] pad_word_t;

	// Turbo tap slot, 0 to 4 are pads
	typedef logic [2:0] slot_t;

	// {bank, select}
	typedef logic [1:0] nib_sel_t;

endpackage

`default_nettype wire

// File: pad_port_mux.sv
/*
 * Port mux
 * Picks the mouse or the pad word and latches the addressed nibble
 */

`default_nettype none

module pad_port_mux (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  pad_pkg::pad_word_t  pad_word,
	input  logic [7:0]          mouse_byte,
	input  logic                slot_first,
	input  logic                mouse_en,
	input  pad_pkg::nib_sel_t   nib_sel,
	input  logic                latch_clear,
	output pad_pkg::nibble_t    joy_in
);

	pad_pkg::pad_word_t  port_word;

	// ==============================
	// Word choice
	// ==============================

	// Mouse sits in the first slot only
	always_comb begin
		if (mouse_en && slot_first)
			port_word = {mouse_byte, mouse_byte};
		else
			port_word = pad_word;
	end

	// ==============================
	// Nibble latch
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			joy_in <= '0;
		end else if (latch_clear) begin
			joy_in <= '0;                  // Reads as all pressed during clear
		end else begin
			joy_in <= port_word[nib_sel];  // Nibble {bank, select}
		end
	end

endmodule

`default_nettype wire

// File: pad_scanner.sv
/*
 * Pad scanner
 * Decodes the console strobes, steps the turbo tap slot and the six-button
 * bank, and forms the active-low word of the addressed pad
 */

`default_nettype none

`include "pad_defines.svh"

module pad_scanner (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic [1:0]           joy_out,    // [0] select, [1] clear
	input  pad_pkg::joy_word_t   joy_a,
	input  pad_pkg::joy_word_t   joy_b,
	input  pad_pkg::joy_word_t   joy_2,
	input  pad_pkg::joy_word_t   joy_3,
	input  pad_pkg::joy_word_t   joy_4,
	input  logic                 joy_swap,
	input  logic                 turbotap,
	input  logic                 buttons6,
	output pad_pkg::pad_word_t   pad_word,
	output pad_pkg::joy_word_t   pad0_buttons,
	output logic                 slot_first,
	output pad_pkg::nib_sel_t    nib_sel,
	output logic                 latch_clear,
	output logic                 clr_rise,
	output logic                 clr_level
);

	localparam pad_pkg::slot_t last_slot = pad_pkg::slot_t'(`PAD_COUNT - 1);

	logic [1:0]          last_joy_out;
	logic                sel_rise;
	pad_pkg::slot_t      slot;
	logic                bank;       // High buttons III to VI
	pad_pkg::joy_word_t  joys [`PAD_COUNT];

	// Console order, active low
	function automatic pad_pkg::pad_word_t pad_remap(input pad_pkg::joy_word_t j);
		pad_remap = ~{4'hF, j[11:8], j[1], j[2], j[0], j[3], j[7:4]};
	endfunction

	// ==============================
	// Strobe edges
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			last_joy_out <= 2'b00;
		end else begin
			last_joy_out <= joy_out;
		end
	end

	assign clr_level   = joy_out[1];
	assign latch_clear = joy_out[1];
	assign clr_rise    = joy_out[1] & ~last_joy_out[1];
	assign sel_rise    = joy_out[0] & ~last_joy_out[0];

	// ==============================
	// Slot and bank
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			slot <= '0;
			bank <= 1'b0;
		end else if (joy_out[1]) begin
			slot <= '0;              // Clear restarts the tap
			if (clr_rise)
				bank <= ~bank & buttons6;
		end else if (sel_rise && turbotap) begin
			slot <= slot + 3'd1;     // Wraps at 8
		end
	end

	assign slot_first = (slot == '0);
	assign nib_sel    = {bank, joy_out[0]};

	// ==============================
	// Pad word
	// ==============================

	// Swap only touches the first two pads
	assign joys[0] = joy_swap ? joy_b : joy_a;
	assign joys[1] = joy_swap ? joy_a : joy_b;
	assign joys[2] = joy_2;
	assign joys[3] = joy_3;
	assign joys[4] = joy_4;

	assign pad0_buttons = joys[0];  // Mouse buttons come from here

	always_comb begin
		if (slot <= last_slot)
			pad_word = pad_remap(joys[slot]);
		else
			pad_word = 16'h0FFF;    // Empty tap slot
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the controller port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pad_input -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_pad_input 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "All tests passed"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: tb_pad_input.sv
/*
 * Controller port testbench
 * Directed tests of the pad scanner, turbo tap, six-button bank and mouse
 * packet against a reference model of the port rules
 */

`default_nettype none

`include "pad_defines.svh"

module tb_pad_input;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD_NS = 4;
	localparam int IDLE_CYCLES   = 32768;        // Mouse idle counter fills before this
	localparam int SHORT_CYCLES  = 1500;         // Rough length of tests 1 to 5 rounded up
	localparam int WATCHDOG_NS   = 2 * (SHORT_CYCLES + IDLE_CYCLES + 200) * CLK_PERIOD_NS;

	logic                clk_sys = 1'b0;
	logic                rst_n;
	logic [1:0]          joy_out;                // [0] select, [1] clear
	pad_pkg::joy_word_t  joy_a;
	pad_pkg::joy_word_t  joy_b;
	pad_pkg::joy_word_t  joy_2;
	pad_pkg::joy_word_t  joy_3;
	pad_pkg::joy_word_t  joy_4;
	logic [8:0]          mouse_x;
	logic [8:0]          mouse_y;
	logic [7:0]          mouse_flags;
	logic                mouse_strobe;
	logic                joy_swap;
	logic                turbotap;
	logic                buttons6;
	logic                mouse_en;
	pad_pkg::nibble_t    joy_in;

	// Reference model state
	logic                m_clr;
	logic                m_sel;
	logic [2:0]          m_slot;
	logic                m_bank;
	logic [1:0]          m_cnt;
	logic [7:0]          m_acc_x;
	logic [7:0]          m_acc_y;
	logic [7:0]          m_cap_x;
	logic [7:0]          m_cap_y;
	logic [15:0]         lfsr_state;
	int                  error_count;

	pad_input_top dut (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.joy_out      (joy_out),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_flags  (mouse_flags),
		.mouse_strobe (mouse_strobe),
		.joy_swap     (joy_swap),
		.turbotap     (turbotap),
		.buttons6     (buttons6),
		.mouse_en     (mouse_en),
		.joy_in       (joy_in)
	);

	always #(CLK_PERIOD_NS / 2) clk_sys = ~clk_sys;

	// ==============================
	// Model
	// ==============================

	// Galois LFSR stepped once per bit
	function automatic logic random_bit();
		logic out_bit;
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit)
			lfsr_state = lfsr_state ^ 16'hB400;
		random_bit = out_bit;
	endfunction

	// Ones on top, then III to VI, left down right up, then I II select run
	function automatic pad_pkg::pad_word_t console_word(input pad_pkg::joy_word_t j);
		logic [3:0] extra;
		logic [3:0] dirs;
		logic [3:0] btns;
		extra = j[11:8];
		dirs = {j[1], j[2], j[0], j[3]};
		btns = j[7:4];
		console_word = ~{4'hF, extra, dirs, btns};
	endfunction

	function automatic pad_pkg::nibble_t expected_nibble();
		pad_pkg::joy_word_t pads [`PAD_COUNT];
		pad_pkg::pad_word_t word;
		logic [3:0]         motion;
		logic [3:0]         mouse_btns;
		pads[0] = joy_swap ? joy_b : joy_a;
		pads[1] = joy_swap ? joy_a : joy_b;
		pads[2] = joy_2;
		pads[3] = joy_3;
		pads[4] = joy_4;
		case (m_cnt)
			2'd0:    motion = m_cap_x[7:4];
			2'd1:    motion = m_cap_x[3:0];
			2'd2:    motion = m_cap_y[7:4];
			default: motion = m_cap_y[3:0];
		endcase
		mouse_btns = ~{pads[0][7], pads[0][6], mouse_flags[0], mouse_flags[1]};
		if (mouse_en && m_slot == 3'd0)
			word = {motion, mouse_btns, motion, mouse_btns};
		else if (int'(m_slot) < `PAD_COUNT)
			word = console_word(pads[m_slot]);
		else
			word = 16'h0FFF;       // Empty tap slot
		if (m_clr)
			expected_nibble = 4'h0;
		else
			expected_nibble = word[{m_bank, m_sel}];
	endfunction

	// ==============================
	// Drive and check
	// ==============================

	task automatic settle();
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);      // Mid cycle where joy_in is stable
	endtask

	task automatic check_value(input string test_name, input logic [3:0] exp,
			input logic [3:0] act);
		assert (act === exp) else begin
			error_count++;
			$display("error in %s: expected %h, actual %h", test_name, exp, act);
			$display("Some tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_nibble(input string test_name);
		check_value(test_name, expected_nibble(), joy_in);
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		rst_n <= 1'b0;
		joy_out <= 2'b00;
		mouse_strobe <= 1'b0;
		@(negedge clk_sys);
		check_value("reset", 4'h0, joy_in);
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		m_clr = 1'b0;
		m_sel = 1'b0;
		m_slot = 3'd0;
		m_bank = 1'b0;
		m_cnt = 2'd3;
		m_acc_x = 8'h00;
		m_acc_y = 8'h00;
		m_cap_x = 8'h00;
		m_cap_y = 8'h00;
	endtask

	task automatic set_options(input logic swap, input logic tap, input logic six,
			input logic mouse);
		@(posedge clk_sys);
		joy_swap <= swap;
		turbotap <= tap;
		buttons6 <= six;
		mouse_en <= mouse;
	endtask

	task automatic load_random_pads();
		pad_pkg::joy_word_t w [`PAD_COUNT];
		int p;
		int b;
		for (p = 0; p < `PAD_COUNT; p++) begin
			w[p] = '0;
			for (b = 0; b < 12; b++)
				w[p][b] = random_bit();
		end
		@(posedge clk_sys);
		joy_a <= w[0];
		joy_b <= w[1];
		joy_2 <= w[2];
		joy_3 <= w[3];
		joy_4 <= w[4];
		settle();
	endtask

	// One strobe write with the model stepped alongside
	task automatic drive_strobe(input logic clr, input logic sel);
		logic clr_rise;
		logic sel_rise;
		clr_rise = clr & ~m_clr;
		sel_rise = sel & ~m_sel;
		@(posedge clk_sys);
		joy_out <= {clr, sel};
		if (clr) begin
			m_slot = 3'd0;
			if (clr_rise)
				m_bank = ~m_bank & buttons6;
		end else if (sel_rise && turbotap) begin
			m_slot = m_slot + 3'd1;
		end
		if (clr_rise) begin
			if (m_cnt == 2'd3) begin   // Packet boundary
				m_cap_x = m_acc_x;
				m_cap_y = m_acc_y;
				m_acc_x = 8'h00;
				m_acc_y = 8'h00;
			end
			m_cnt = m_cnt + 2'd1;
		end
		m_clr = clr;
		m_sel = sel;
		settle();
	endtask

	task automatic strobe_mouse(input logic [8:0] x, input logic [8:0] y,
			input logic [7:0] flags);
		@(posedge clk_sys);
		mouse_x <= x;
		mouse_y <= y;
		mouse_flags <= flags;
		mouse_strobe <= 1'b1;
		@(posedge clk_sys);
		mouse_strobe <= 1'b0;
		m_acc_x = 8'd0 - x[7:0];
		m_acc_y = y[7:0];
		settle();
	endtask

	// Clear pulse, then select high and low
	task automatic clear_and_read(input string test_name);
		drive_strobe(1'b1, 1'b1);
		check_nibble(test_name);
		drive_strobe(1'b0, 1'b1);
		check_nibble(test_name);
		drive_strobe(1'b0, 1'b0);
		check_nibble(test_name);
	endtask

	// ==============================
	// Tests
	// ==============================

	task automatic test_reset_and_clear();
		apply_reset();
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
		drive_strobe(1'b1, 1'b0);
		check_nibble("reset_and_clear");
		drive_strobe(1'b0, 1'b0);
		check_nibble("reset_and_clear");
	endtask

	task automatic test_single_pad();
		apply_reset();
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
		repeat (4) begin
			load_random_pads();
			clear_and_read("single_pad");
		end
		set_options(1'b1, 1'b0, 1'b0, 1'b0);   // Pad 0 now reads joy_b
		repeat (4) begin
			load_random_pads();
			clear_and_read("single_pad_swap");
		end
	endtask

	task automatic test_turbo_tap();
		apply_reset();
		set_options(1'b0, 1'b1, 1'b0, 1'b0);
		load_random_pads();
		clear_and_read("turbo_tap");
		repeat (8) begin                        // Slots 1 to 7, then back to 0
			drive_strobe(1'b0, 1'b1);
			check_nibble("turbo_tap");
			drive_strobe(1'b0, 1'b0);
			check_nibble("turbo_tap");
		end
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
		clear_and_read("turbo_tap_off");
		repeat (3) begin
			drive_strobe(1'b0, 1'b1);
			check_nibble("turbo_tap_off");
			drive_strobe(1'b0, 1'b0);
			check_nibble("turbo_tap_off");
		end
	endtask

	task automatic test_six_button();
		apply_reset();
		set_options(1'b0, 1'b0, 1'b1, 1'b0);
		load_random_pads();
		repeat (4)
			clear_and_read("six_button");      // Bank toggles per pulse
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
		repeat (2)
			clear_and_read("six_button_off");
	endtask

	task automatic test_mouse();
		apply_reset();
		set_options(1'b0, 1'b0, 1'b0, 1'b1);
		load_random_pads();
		strobe_mouse(9'h013, 9'h1A5, 8'h02);
		repeat (4)
			clear_and_read("mouse");
		strobe_mouse(9'h1C0, 9'h07E, 8'h01);
		repeat (4)
			clear_and_read("mouse_second");
	endtask

	task automatic test_mouse_timeout();
		apply_reset();
		set_options(1'b0, 1'b0, 1'b0, 1'b1);
		load_random_pads();
		strobe_mouse(9'h02B, 9'h0F1, 8'h00);
		repeat (2)
			clear_and_read("mouse_timeout");   // Packet left at x low
		strobe_mouse(9'h0A0, 9'h140, 8'h03);
		repeat (IDLE_CYCLES) @(posedge clk_sys);
		m_cnt = 2'd3;                          // Idle counter full so the packet restarts
		@(negedge clk_sys);
		check_nibble("mouse_timeout");
		drive_strobe(1'b0, 1'b1);
		check_nibble("mouse_timeout");
		clear_and_read("mouse_timeout");      // x high of the new capture
	endtask

	// ==============================
	// Run
	// ==============================

	initial begin
		rst_n = 1'b0;
		joy_out = 2'b00;
		joy_a = '0;
		joy_b = '0;
		joy_2 = '0;
		joy_3 = '0;
		joy_4 = '0;
		mouse_x = 9'h000;
		mouse_y = 9'h000;
		mouse_flags = 8'h00;
		mouse_strobe = 1'b0;
		joy_swap = 1'b0;
		turbotap = 1'b0;
		buttons6 = 1'b0;
		mouse_en = 1'b0;
		lfsr_state = 16'd45190;
		error_count = 0;

		test_reset_and_clear();
		test_single_pad();
		test_turbo_tap();
		test_six_button();
		test_mouse();
		test_mouse_timeout();

		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Some tests failed");
		$fatal(1, "simulation timeout");
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
pad_pkg.sv
mouse_pkg.sv
pad_scanner.sv
mouse_encoder.sv
pad_port_mux.sv
pad_input_top.sv
tb_pad_input.sv
